// ==== source/block_buffer.sv ====
// Input FIFO that parks source/prediction pairs until the flow control launches them
`timescale 1ns/1ps
`default_nettype none

module block_buffer (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 wr_i,
    input  wire fdct_pkg::pix_blk_t src_i,
    input  wire fdct_pkg::pix_blk_t pred_i,
    input  wire                 pop_i,
    output logic                not_empty_o,
    output fdct_pkg::pix_blk_t  head_src_o,
    output fdct_pkg::pix_blk_t  head_pred_o
);

    import fdct_pkg::*;

    typedef logic [$clog2(BUF_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(BUF_DEPTH+1)-1:0] occ_t;

    pix_blk_t src_mem  [BUF_DEPTH];
    pix_blk_t pred_mem [BUF_DEPTH];

    ptr_t wr_ptr_q;
    ptr_t rd_ptr_q;
    occ_t occ_q;    // Entries held

    // Pointer advance with wrap at the last entry
    function automatic ptr_t ptr_inc(input ptr_t p);
        return (p == ptr_t'(BUF_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (wr_i) begin
            src_mem[wr_ptr_q]  <= src_i;
            pred_mem[wr_ptr_q] <= pred_i;
        end
    end

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            occ_q    <= '0;
        end else begin
            if (wr_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({wr_i, pop_i})
                2'b10:   occ_q <= occ_q + 1'b1;
                2'b01:   occ_q <= occ_q - 1'b1;
                default: occ_q <= occ_q;    // Write and pop together cancel
            endcase
        end
    end

    // Oldest pair straight out of the array
    assign head_src_o  = src_mem[rd_ptr_q];
    assign head_pred_o = pred_mem[rd_ptr_q];
    assign not_empty_o = (occ_q != '0);

endmodule

`default_nettype wire

// ==== source/fdct_col_stage.sv ====
// Second transform pass, vertical butterflies with rounding into the coefficient register
`timescale 1ns/1ps
`default_nettype none

module fdct_col_stage (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 load_i,
    input  wire fdct_pkg::tmp_blk_t tmp_i,
    output fdct_pkg::coef_blk_t coef_o
);

    import fdct_pkg::*;

    coef_blk_t coef_d;
    coef_blk_t coef_q;

    // ----------------------------------------
    // Vertical butterflies per column
    // ----------------------------------------
    always_comb begin
        logic signed [14:0] b0;
        logic signed [14:0] b1;
        logic signed [14:0] b2;
        logic signed [14:0] b3;
        logic signed [31:0] e0;
        logic signed [31:0] e2;
        logic signed [31:0] o1;
        logic signed [31:0] o3;
        for (int c = 0; c < 4; c++) begin
            b0 = tmp_i[c+0] + tmp_i[c+12];    // Outer sum
            b1 = tmp_i[c+4] + tmp_i[c+8];     // Inner sum
            b2 = tmp_i[c+4] - tmp_i[c+8];     // Inner difference
            b3 = tmp_i[c+0] - tmp_i[c+12];    // Outer difference

            // Even rows round by 7 then drop four bits
            e0 = (b0 + b1 + 7) >>> 4;
            e2 = (b0 - b1 + 7) >>> 4;

            // Row 1 picks up one more whenever the outer difference is nonzero
            o1 = ((b2 * K_A + b3 * K_B + K_C1) >>> 16) + ((b3 != 0) ? 1 : 0);
            o3 = (b3 * K_A - b2 * K_B + K_C3) >>> 16;

            coef_d[c+0]  = coef_t'(e0);
            coef_d[c+4]  = coef_t'(o1);
            coef_d[c+8]  = coef_t'(e2);
            coef_d[c+12] = coef_t'(o3);
        end
    end

    // ----------------------------------------
    // Coefficient register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            coef_q <= '0;
        end else if (load_i) begin
            coef_q <= coef_d;
        end
    end

    // Holds between loads
    assign coef_o = coef_q;

endmodule

`default_nettype wire

// ==== source/fdct_flow_ctrl.sv ====
// Launch control that tracks output credits and walks each launched block through both stages
`timescale 1ns/1ps
`default_nettype none

module fdct_flow_ctrl (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  in_valid_i,
    input  wire  not_empty_i,
    input  wire  out_credit_i,
    output logic pop_o,
    output logic col_en_o,
    output logic out_valid_o,
    output logic in_credit_o
);

    import fdct_pkg::*;

    credit_cnt_t out_cnt_q;    // Output credits still free
    logic        launch;
    logic        col_en_q;     // Row register holds a live block
    logic        out_valid_q;  // Column register holds a live block
    logic        in_credit_q;

    // ----------------------------------------
    // Launch decision
    // ----------------------------------------
    assign launch = not_empty_i && (out_cnt_q != '0);
    assign pop_o  = launch;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_cnt_q <= credit_cnt_t'(OUT_CREDITS);
        end else begin
            case ({launch, out_credit_i})
                2'b10:   out_cnt_q <= out_cnt_q - 1'b1;    // Reserved at launch
                2'b01:   out_cnt_q <= out_cnt_q + 1'b1;    // Sink gave one back
                default: out_cnt_q <= out_cnt_q;
            endcase
        end
    end

    // ----------------------------------------
    // Stage valid bits and input credit
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_en_q    <= 1'b0;
            out_valid_q <= 1'b0;
            in_credit_q <= 1'b0;
        end else begin
            col_en_q    <= launch;
            out_valid_q <= col_en_q;
            in_credit_q <= launch;    // Entry freed by this pop
        end
    end

    assign col_en_o    = col_en_q;
    assign out_valid_o = out_valid_q;
    assign in_credit_o = in_credit_q;

endmodule

`default_nettype wire

// ==== source/fdct_pkg.sv ====
// Widths, transform constants, credit sizes and block types shared by every fdct module
`default_nettype none

package fdct_pkg;

    // ----------------------------------------
    // Data widths
    // ----------------------------------------
    localparam int PIX_W  = 8;     // Source and prediction pixels
    localparam int BLK_N  = 16;    // Entries per 4x4 block
    localparam int TMP_W  = 14;    // Row pass output
    localparam int COEF_W = 12;    // Final coefficient

    // ----------------------------------------
    // Transform constants
    // ----------------------------------------
    localparam int K_A  = 2217;
    localparam int K_B  = 5352;
    localparam int K_R1 = 1812;    // Row odd 1 rounding
    localparam int K_R3 = 937;     // Row odd 3 rounding
    localparam int K_C1 = 12000;   // Column odd 1 rounding
    localparam int K_C3 = 51000;   // Column odd 3 rounding

    // ----------------------------------------
    // Flow control sizing
    // ----------------------------------------
    localparam int BUF_DEPTH   = 2;   // Also the sender's starting credit
    localparam int OUT_CREDITS = 4;
    localparam int CREDIT_W    = 3;

    // Block types, entry 0 in the lowest bits, raster order
    typedef logic [PIX_W-1:0] pix_t;
    typedef pix_t [BLK_N-1:0] pix_blk_t;

    typedef logic signed [TMP_W-1:0] tmp_t;
    typedef tmp_t [BLK_N-1:0] tmp_blk_t;

    typedef logic signed [COEF_W-1:0] coef_t;
    typedef coef_t [BLK_N-1:0] coef_blk_t;

    typedef logic [CREDIT_W-1:0] credit_cnt_t;

endpackage

`default_nettype wire

// ==== source/fdct_row_stage.sv ====
// First transform pass, subtracts prediction from source and runs the horizontal butterflies
`timescale 1ns/1ps
`default_nettype none

module fdct_row_stage (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 load_i,
    input  wire fdct_pkg::pix_blk_t src_i,
    input  wire fdct_pkg::pix_blk_t pred_i,
    output fdct_pkg::tmp_blk_t  tmp_o
);

    import fdct_pkg::*;

    tmp_blk_t tmp_d;
    tmp_blk_t tmp_q;

    // 9-bit signed difference of two unsigned pixels
    function automatic logic signed [8:0] residual(input pix_t s, input pix_t p);
        return $signed({1'b0, s}) - $signed({1'b0, p});
    endfunction

    // ----------------------------------------
    // Horizontal butterflies, one row at a time
    // ----------------------------------------
    always_comb begin
        logic signed [8:0]  d0;
        logic signed [8:0]  d1;
        logic signed [8:0]  d2;
        logic signed [8:0]  d3;
        logic signed [9:0]  a0;
        logic signed [9:0]  a1;
        logic signed [9:0]  a2;
        logic signed [9:0]  a3;
        logic signed [10:0] e_sum;
        logic signed [10:0] e_dif;
        logic signed [31:0] o1;
        logic signed [31:0] o3;
        for (int r = 0; r < 4; r++) begin
            d0 = residual(src_i[4*r+0], pred_i[4*r+0]);
            d1 = residual(src_i[4*r+1], pred_i[4*r+1]);
            d2 = residual(src_i[4*r+2], pred_i[4*r+2]);
            d3 = residual(src_i[4*r+3], pred_i[4*r+3]);

            a0 = d0 + d3;    // Outer sum
            a1 = d1 + d2;    // Inner sum
            a2 = d1 - d2;    // Inner difference
            a3 = d0 - d3;    // Outer difference

            e_sum = a0 + a1;
            e_dif = a0 - a1;
            o1    = (a2 * K_A + a3 * K_B + K_R1) >>> 9;
            o3    = (a3 * K_A - a2 * K_B + K_R3) >>> 9;

            // Even terms scaled by 8
            tmp_d[4*r+0] = tmp_t'(e_sum) <<< 3;
            tmp_d[4*r+1] = tmp_t'(o1);
            tmp_d[4*r+2] = tmp_t'(e_dif) <<< 3;
            tmp_d[4*r+3] = tmp_t'(o3);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tmp_q <= '0;
        end else if (load_i) begin
            tmp_q <= tmp_d;    // Captured on the popping edge
        end
    end

    assign tmp_o = tmp_q;

endmodule

`default_nettype wire

// ==== source/fdct_top.sv ====
// Top of the forward 4x4 transform, credit handshake on both sides and a two-stage datapath
`timescale 1ns/1ps
`default_nettype none

module fdct_top (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 in_valid_i,
    input  wire fdct_pkg::pix_blk_t src_i,
    input  wire fdct_pkg::pix_blk_t pred_i,
    output logic                in_credit_o,
    output logic                out_valid_o,
    output fdct_pkg::coef_blk_t coef_o,
    input  wire                 out_credit_i
);

    import fdct_pkg::*;

    // ----------------------------------------
    // Internal wiring
    // ----------------------------------------
    logic     buf_not_empty;
    logic     pop;          // Also loads the row register
    logic     col_en;       // Row stage valid
    pix_blk_t head_src;
    pix_blk_t head_pred;
    tmp_blk_t tmp_blk;

    block_buffer block_buffer_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_i        (in_valid_i),
        .src_i       (src_i),
        .pred_i      (pred_i),
        .pop_i       (pop),
        .not_empty_o (buf_not_empty),
        .head_src_o  (head_src),
        .head_pred_o (head_pred)
    );

    fdct_flow_ctrl fdct_flow_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid_i   (in_valid_i),
        .not_empty_i  (buf_not_empty),
        .out_credit_i (out_credit_i),
        .pop_o        (pop),
        .col_en_o     (col_en),
        .out_valid_o  (out_valid_o),
        .in_credit_o  (in_credit_o)
    );

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    fdct_row_stage fdct_row_stage_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .load_i (pop),
        .src_i  (head_src),
        .pred_i (head_pred),
        .tmp_o  (tmp_blk)
    );

    fdct_col_stage fdct_col_stage_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .load_i (col_en),
        .tmp_i  (tmp_blk),
        .coef_o (coef_o)
    );

endmodule

`default_nettype wire

// ==== tb/fdct_ref_model.svh ====
// Expected coefficients for a source/prediction pair and the LCG, included inside fdct_tb
`ifndef FDCT_REF_MODEL_SVH
`define FDCT_REF_MODEL_SVH

// Next LCG state
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// Forward 4x4 transform on plain integers
function automatic coef_blk_t fdct_ref(input pix_blk_t src, input pix_blk_t pred);
    int        d [16];
    int        t [16];
    int        s03;
    int        s12;
    int        d12;
    int        d03;
    coef_blk_t res;
    for (int i = 0; i < 16; i++) begin
        d[i] = int'(src[i]) - int'(pred[i]);
    end
    // ----------------------------------------
    // Rows
    for (int r = 0; r < 4; r++) begin
        s03 = d[4*r] + d[4*r+3];
        s12 = d[4*r+1] + d[4*r+2];
        d12 = d[4*r+1] - d[4*r+2];
        d03 = d[4*r] - d[4*r+3];
        t[4*r]   = (s03 + s12) * 8;
        t[4*r+2] = (s03 - s12) * 8;
        t[4*r+1] = (d12 * K_A + d03 * K_B + K_R1) >>> 9;
        t[4*r+3] = (d03 * K_A - d12 * K_B + K_R3) >>> 9;
    end
    // ----------------------------------------
    // Columns
    for (int c = 0; c < 4; c++) begin
        s03 = t[c] + t[c+12];
        s12 = t[c+4] + t[c+8];
        d12 = t[c+4] - t[c+8];
        d03 = t[c] - t[c+12];
        res[c]    = coef_t'((s03 + s12 + 7) >>> 4);
        res[c+8]  = coef_t'((s03 - s12 + 7) >>> 4);
        res[c+4]  = coef_t'(((d12 * K_A + d03 * K_B + K_C1) >>> 16) + (d03 != 0));
        res[c+12] = coef_t'((d03 * K_A - d12 * K_B + K_C3) >>> 16);
    end
    return res;
endfunction

`endif

// ==== tb/fdct_tb.sv ====
// Self-checking testbench driving random and corner blocks through fdct_top and both credit handshakes
`timescale 1ns/1ps
`default_nettype none

module fdct_tb;
    import fdct_pkg::*;

    `include "fdct_ref_model.svh"

    localparam logic [31:0] SEED = 32'hf311a230;
    localparam int N_RANDOM   = 200;
    localparam int WAIT_LIMIT = 500;    // Cycles per wait loop

    logic      clk;
    logic      rst_n;
    logic      in_valid_i;
    pix_blk_t  src_i;
    pix_blk_t  pred_i;
    logic      in_credit_o;
    logic      out_valid_o;
    coef_blk_t coef_o;
    logic      out_credit_i;

    logic [31:0] data_lcg;
    logic [31:0] delay_lcg;
    coef_blk_t   exp_q [$];       // Expected results in sending order
    int          credit_due [$];  // Sink delay per consumed block
    logic        hold_credits;
    int snd_credits;
    int blocks_sent;
    int in_credit_total;
    int out_pulses;
    int cycle;
    int accept_cycle;
    int last_in_credit_cycle;
    int last_out_cycle;
    int coef_errors;
    int count_errors;
    int flag_errors;
    int other_errors;
    int start;
    pix_blk_t s_blk;
    pix_blk_t p_blk;

    fdct_top fdct_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid_i   (in_valid_i),
        .src_i        (src_i),
        .pred_i       (pred_i),
        .in_credit_o  (in_credit_o),
        .out_valid_o  (out_valid_o),
        .coef_o       (coef_o),
        .out_credit_i (out_credit_i)
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_coef(input coef_blk_t got, input coef_blk_t exp);
        for (int i = 0; i < BLK_N; i++) begin
            if (got[i] !== exp[i]) begin
                $display("[FAIL] %0t coef_o[%0d] got %0d expected %0d", $time, i, got[i], exp[i]);
                coef_errors++;
            end
        end
    endtask

    task automatic check_count(input string name, input credit_cnt_t got, input credit_cnt_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            count_errors++;
        end
    endtask

    task automatic check_total(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            count_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            flag_errors++;
        end
    endtask

    function automatic pix_blk_t rand_block();
        pix_blk_t blk;
        for (int i = 0; i < BLK_N; i++) begin
            data_lcg = lcg_next(data_lcg);
            blk[i]   = data_lcg[23:16];
        end
        return blk;
    endfunction

    // ----------------------------------------
    // Sender waits for an input credit before each block
    // ----------------------------------------
    task automatic send_block(input pix_blk_t s, input pix_blk_t p);
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid_i = 1'b0;
        while (snd_credits <= 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (snd_credits <= 0) begin
            $display("Timed out at %0t waiting for an input credit", $time);
            other_errors++;
        end else begin
            src_i      = s;
            pred_i     = p;
            in_valid_i = 1'b1;
            snd_credits--;
            blocks_sent++;
            accept_cycle = cycle + 1;    // Next rising edge
            exp_q.push_back(fdct_ref(s, p));
        end
    endtask

    task automatic wait_pulses(input int target);
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid_i = 1'b0;
        while (out_pulses < target && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (out_pulses < target) begin
            $display("Timed out at %0t waiting for out_valid_o pulse %0d", $time, target);
            other_errors++;
        end
    endtask

    // Every expected block out and no sink credit still pending
    task automatic wait_drained();
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid_i = 1'b0;
        while ((exp_q.size() != 0 || credit_due.size() != 0)
               && waited < 4 * WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0 || credit_due.size() != 0) begin
            $display("Timed out at %0t waiting for the pipeline to drain", $time);
            other_errors++;
        end
        repeat (2) @(negedge clk);
    endtask

    // ----------------------------------------
    // Port monitor and scoreboard
    // ----------------------------------------
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (in_credit_o === 1'b1) begin
            in_credit_total++;
            snd_credits++;
            last_in_credit_cycle = cycle;
            if (snd_credits > BUF_DEPTH) begin
                $display("Input credit returned with no buffer entry used at %0t", $time);
                other_errors++;
            end
        end
        if (out_valid_o === 1'b1) begin
            out_pulses++;
            last_out_cycle = cycle;
            delay_lcg = lcg_next(delay_lcg);
            credit_due.push_back(int'(delay_lcg[18:16]));
            if (exp_q.size() == 0) begin
                $display("out_valid_o pulsed at %0t with no block outstanding", $time);
                other_errors++;
            end else begin
                check_coef(coef_o, exp_q.pop_front());
            end
        end
    end

    // Sink returns one credit per block after its delay
    always @(negedge clk) begin
        out_credit_i <= 1'b0;
        if (!hold_credits && credit_due.size() > 0) begin
            if (credit_due[0] == 0) begin
                void'(credit_due.pop_front());
                out_credit_i <= 1'b1;
            end else begin
                credit_due[0] = credit_due[0] - 1;
            end
        end
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid_i = 1'b0;
        src_i = '0;
        pred_i = '0;
        out_credit_i = 1'b0;
        hold_credits = 1'b1;
        data_lcg = SEED;
        delay_lcg = lcg_next(~SEED);
        snd_credits = BUF_DEPTH;
        blocks_sent = 0;
        in_credit_total = 0;
        out_pulses = 0;
        cycle = 0;
        coef_errors = 0;
        count_errors = 0;
        flag_errors = 0;
        other_errors = 0;

        repeat (10) begin
            @(negedge clk);
            check_flag("out_valid_o", out_valid_o, 1'b0);
            check_flag("in_credit_o", in_credit_o, 1'b0);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("out_valid_o", out_valid_o, 1'b0);
        check_flag("in_credit_o", in_credit_o, 1'b0);

        // First blocks ride on the initial output credits
        repeat (OUT_CREDITS) send_block(rand_block(), rand_block());
        wait_pulses(OUT_CREDITS);
        check_count("out_valid_o pulses before credit", credit_cnt_t'(out_pulses),
                    credit_cnt_t'(OUT_CREDITS));
        hold_credits = 1'b0;
        wait_drained();

        // Latency through an empty pipeline
        start = out_pulses;
        send_block({BLK_N{8'hff}}, {BLK_N{8'h00}});
        wait_pulses(start + 1);
        check_total("in_credit_o cycle", last_in_credit_cycle, accept_cycle + 2);
        check_total("out_valid_o cycle", last_out_cycle, accept_cycle + 3);
        check_flag("out_valid_o", out_valid_o, 1'b0);

        // Remaining corners
        send_block({BLK_N{8'h00}}, {BLK_N{8'hff}});
        s_blk = rand_block();
        send_block(s_blk, s_blk);
        s_blk = '0;
        s_blk[5] = 8'd200;
        send_block(s_blk, '0);
        wait_drained();

        // ----------------------------------------
        // Output credits withheld
        start = out_pulses;
        hold_credits = 1'b1;
        repeat (OUT_CREDITS + BUF_DEPTH) begin
            s_blk = rand_block();
            p_blk = rand_block();
            send_block(s_blk, p_blk);
        end
        wait_pulses(start + OUT_CREDITS);
        repeat (20) @(negedge clk);
        check_count("out_valid_o pulses while held", credit_cnt_t'(out_pulses - start),
                    credit_cnt_t'(OUT_CREDITS));
        check_count("sender credits while held", credit_cnt_t'(snd_credits), '0);
        hold_credits = 1'b0;
        wait_drained();
        check_total("blocks after release", out_pulses - start, OUT_CREDITS + BUF_DEPTH);

        for (int n = 0; n < N_RANDOM; n++) begin
            s_blk = rand_block();
            p_blk = rand_block();
            send_block(s_blk, p_blk);
        end
        wait_drained();

        check_total("in_credit_o pulses", in_credit_total, blocks_sent);
        check_total("out_valid_o pulses", out_pulses, blocks_sent);
        check_count("sender credits", credit_cnt_t'(snd_credits), credit_cnt_t'(BUF_DEPTH));
        $display("Errors: coef %0d, count %0d, flag %0d, other %0d",
                 coef_errors, count_errors, flag_errors, other_errors);
        if (coef_errors + count_errors + flag_errors + other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+tb
source/fdct_pkg.sv
source/block_buffer.sv
source/fdct_row_stage.sv
source/fdct_col_stage.sv
source/fdct_flow_ctrl.sv
source/fdct_top.sv
tb/fdct_tb.sv
